// File: common/trap_config.svh
// ------------------------------
// Trap controller configuration
// Widths, machine CSR numbers, interrupt cause codes and reset values
// ------------------------------
`ifndef TRAP_CONFIG_SVH
`define TRAP_CONFIG_SVH

// Widths ------------------------
`define TRAP_XLEN        32             // Data and address width
`define TRAP_CSR_AW      12             // APB address, same as CSR number

// Machine CSR numbers -----------
`define CSR_MSTATUS      12'h300        // Global enable and saved enable
`define CSR_MIE          12'h304        // Per-line interrupt enables
`define CSR_MTVEC        12'h305        // Trap vector base and mode
`define CSR_MEPC         12'h341        // Return address
`define CSR_MCAUSE       12'h342        // Trap cause word
`define CSR_MTVAL        12'h343        // Trap value
`define CSR_MIP          12'h344        // Pending lines, read only

// Interrupt cause codes. These are also the bit positions in mie and mip
`define IRQ_CODE_EXT     11             // Machine external
`define IRQ_CODE_SW      3              // Machine software
`define IRQ_CODE_TI      7              // Machine timer

// Reset values ------------------
`define TRAP_MTVEC_RESET 32'h0000_0100  // Base 0x100, direct mode

`endif

// File: common/trap_pkg.sv
// ------------------------------
// Trap controller types
// Packed structs for the APB port, interrupt lines, trap requests
// and the trap update into the CSR file
// ------------------------------
`include "trap_config.svh"

package trap_pkg;

    // APB ---------------------------
    typedef struct packed {
        logic                    psel;     // Slave selected
        logic                    penable;  // Access phase
        logic                    pwrite;   // Write, else read
        logic [`TRAP_CSR_AW-1:0] paddr;    // CSR number
        logic [`TRAP_XLEN-1:0]   pwdata;   // Write data
    } apb_req_t;

    typedef struct packed {
        logic [`TRAP_XLEN-1:0]   prdata;   // Read data, valid in access phase
        logic                    pready;   // No wait states
        logic                    pslverr;  // Unmapped or read-only target
    } apb_rsp_t;

    // Interrupts --------------------
    typedef struct packed {
        logic ext;                         // External line
        logic sw;                          // Software line
        logic ti;                          // Timer line
    } irq_vec_t;

    // Traps -------------------------
    typedef struct packed {
        logic [4:0]              cause;    // Exception code
        logic [`TRAP_XLEN-1:0]   pc;       // Faulting instruction
        logic [`TRAP_XLEN-1:0]   tval;     // Bad address or instruction
    } trap_req_t;

    typedef struct packed {
        logic                    enter;    // Trap taken this cycle
        logic                    ret;      // Return taken this cycle
        logic [`TRAP_XLEN-1:0]   mcause;   // Full cause word
        logic [`TRAP_XLEN-1:0]   mepc;     // Pc to save
        logic [`TRAP_XLEN-1:0]   mtval;    // Value to save
    } csr_trap_t;

endpackage

// File: hw/csr/csr_file.sv
// ------------------------------
// Machine CSR file
// Holds the trap CSRs, serves software over APB and applies
// trap entry and return updates from the sequencer
// ------------------------------
`timescale 1ns/1ps
`include "trap_config.svh"

module csr_file (
    input  logic                  g_clk,        // Core clock
    input  logic                  rst,          // Sync reset, active high
    input  trap_pkg::apb_req_t    apb_req,      // Software access
    output trap_pkg::apb_rsp_t    apb_rsp,      // Access response
    input  trap_pkg::csr_trap_t   csr_trap,     // Entry / return update
    input  trap_pkg::irq_vec_t    mip,          // Pending lines
    output logic                  mstatus_mie,  // Global interrupt enable
    output trap_pkg::irq_vec_t    mie,          // Per-line enables
    output logic [`TRAP_XLEN-1:0] mtvec,        // Base and mode
    output logic [`TRAP_XLEN-1:0] mepc          // Return address
);

    logic                  mstatus_mpie;  // Enable saved at trap entry
    logic [`TRAP_XLEN-1:0] mcause;        // Last trap cause
    logic [`TRAP_XLEN-1:0] mtval;         // Last trap value
    logic                  access;        // APB access phase
    logic                  hit;           // Address decodes to a CSR
    logic                  err;           // Access rejected
    logic                  wr_en;         // Write accepted
    logic [`TRAP_XLEN-1:0] rdata;         // Read mux

    // Decode and read mux -----------
    always_comb begin
        hit   = 1'b1;
        rdata = '0;
        case (apb_req.paddr)
            `CSR_MSTATUS: begin
                rdata[3] = mstatus_mie;
                rdata[7] = mstatus_mpie;
            end
            `CSR_MIE: begin
                rdata[`IRQ_CODE_EXT] = mie.ext;
                rdata[`IRQ_CODE_SW]  = mie.sw;
                rdata[`IRQ_CODE_TI]  = mie.ti;
            end
            `CSR_MIP: begin
                rdata[`IRQ_CODE_EXT] = mip.ext;
                rdata[`IRQ_CODE_SW]  = mip.sw;
                rdata[`IRQ_CODE_TI]  = mip.ti;
            end
            `CSR_MTVEC:  rdata = mtvec;
            `CSR_MEPC:   rdata = mepc;
            `CSR_MCAUSE: rdata = mcause;
            `CSR_MTVAL:  rdata = mtval;
            default:     hit   = 1'b0;         // Unmapped
        endcase
    end

    assign access = apb_req.psel && apb_req.penable;
    // mip follows the lines only, software cannot write it
    assign err    = access && (!hit || (apb_req.pwrite && apb_req.paddr == `CSR_MIP));
    assign wr_en  = access && apb_req.pwrite && !err;

    assign apb_rsp.prdata  = rdata;
    assign apb_rsp.pready  = access;           // Zero wait states
    assign apb_rsp.pslverr = err;

    // Register updates --------------
    always_ff @(posedge g_clk) begin
        if (rst) begin
            mstatus_mie  <= 1'b0;
            mstatus_mpie <= 1'b0;
            mie          <= '0;
            mtvec        <= `TRAP_MTVEC_RESET;
            mepc         <= '0;
            mcause       <= '0;
            mtval        <= '0;
        end else if (csr_trap.enter) begin     // Trap wins over a software write
            mstatus_mpie <= mstatus_mie;
            mstatus_mie  <= 1'b0;              // Handler runs masked
            mepc         <= csr_trap.mepc;
            mcause       <= csr_trap.mcause;
            mtval        <= csr_trap.mtval;
        end else if (csr_trap.ret) begin
            mstatus_mie  <= mstatus_mpie;
            mstatus_mpie <= 1'b1;
        end else if (wr_en) begin
            case (apb_req.paddr)
                `CSR_MSTATUS: begin
                    mstatus_mie  <= apb_req.pwdata[3];
                    mstatus_mpie <= apb_req.pwdata[7];
                end
                `CSR_MIE: begin
                    mie.ext <= apb_req.pwdata[`IRQ_CODE_EXT];
                    mie.sw  <= apb_req.pwdata[`IRQ_CODE_SW];
                    mie.ti  <= apb_req.pwdata[`IRQ_CODE_TI];
                end
                `CSR_MTVEC:  mtvec  <= apb_req.pwdata;
                `CSR_MEPC:   mepc   <= apb_req.pwdata;
                `CSR_MCAUSE: mcause <= apb_req.pwdata;
                `CSR_MTVAL:  mtval  <= apb_req.pwdata;
                default: ;
            endcase
        end
    end

endmodule

// File: hw/irq/irq_prio.sv
// ------------------------------
// Interrupt sampling and priority
// Registers the lines into mip, picks external over software
// over timer, and forms the cause word and trap vector
// ------------------------------
`timescale 1ns/1ps
`include "trap_config.svh"

module irq_prio (
    input  logic                  g_clk,        // Core clock
    input  logic                  rst,          // Sync reset, active high
    input  trap_pkg::irq_vec_t    irq,          // Raw interrupt lines
    input  trap_pkg::irq_vec_t    mie,          // Per-line enables
    input  logic                  mstatus_mie,  // Global enable
    input  logic [`TRAP_XLEN-1:0] mtvec,        // Base and mode
    output trap_pkg::irq_vec_t    mip,          // Sampled lines
    output logic                  int_request,  // Enabled interrupt pending
    output logic [`TRAP_XLEN-1:0] int_cause,    // Cause word, bit 31 set
    output logic [`TRAP_XLEN-1:0] int_tvec      // Handler address
);

    import trap_pkg::*;

    irq_vec_t              masked;  // Pending and enabled
    logic [4:0]            code;    // Winning cause code
    logic [`TRAP_XLEN-1:0] base;    // mtvec with mode bits cleared

    always_ff @(posedge g_clk) begin
        if (rst) begin
            mip <= '0;
        end else begin
            mip <= irq;                           // One cycle of sampling
        end
    end

    assign masked      = mip & mie;
    assign int_request = mstatus_mie && (|masked);

    // Fixed priority
    always_comb begin
        if (masked.ext) begin
            code = 5'(`IRQ_CODE_EXT);
        end else if (masked.sw) begin
            code = 5'(`IRQ_CODE_SW);
        end else begin
            code = 5'(`IRQ_CODE_TI);
        end
    end

    assign int_cause = {1'b1, {(`TRAP_XLEN-6){1'b0}}, code};
    assign base      = {mtvec[`TRAP_XLEN-1:2], 2'b00};

    // Vectored mode jumps to base + 4 * code
    assign int_tvec  = (mtvec[1:0] == 2'b01) ?
                       base + {{(`TRAP_XLEN-7){1'b0}}, code, 2'b00} : base;

endmodule

// File: hw/trap_seq.sv
// ------------------------------
// Trap sequencer
// Accepts exceptions, returns and interrupts by priority, updates
// the CSRs and holds one redirect until it is acknowledged
// ------------------------------
`timescale 1ns/1ps
`include "trap_config.svh"

module trap_seq (
    input  logic                  g_clk,          // Core clock
    input  logic                  rst,            // Sync reset, active high
    input  logic                  exc_valid,      // Exception request
    input  trap_pkg::trap_req_t   exc_req,        // Cause, pc and value
    output logic                  exc_ready,      // Free to take a trap
    input  logic                  mret_valid,     // Return request
    output logic                  mret_ready,     // Free to take a return
    input  logic                  int_request,    // Enabled interrupt pending
    input  logic [`TRAP_XLEN-1:0] int_cause,      // Interrupt cause word
    input  logic [`TRAP_XLEN-1:0] int_tvec,       // Interrupt handler
    input  logic [`TRAP_XLEN-1:0] mepc,           // Return address
    input  logic [`TRAP_XLEN-1:0] mtvec,          // Exception handler base
    output trap_pkg::csr_trap_t   csr_trap,       // CSR update
    output logic                  trap_cf_valid,  // Redirect held
    output logic [`TRAP_XLEN-1:0] trap_cf_target, // Redirect address
    input  logic                  trap_cf_ack     // Redirect consumed
);

    logic                  hold;         // One redirect in flight
    logic                  take_exc;     // Accept exception
    logic                  take_ret;     // Accept return
    logic                  take_int;     // Accept interrupt
    logic [`TRAP_XLEN-1:0] next_target;  // Target to load

    assign exc_ready  = !hold;
    assign mret_ready = !hold;

    // Exception, then return, then interrupt
    assign take_exc = exc_valid && !hold;
    assign take_ret = mret_valid && !hold && !exc_valid;
    assign take_int = int_request && !hold && !exc_valid && !mret_valid;

    always_comb begin
        csr_trap.enter  = take_exc || take_int;
        csr_trap.ret    = take_ret;
        csr_trap.mcause = '0;
        csr_trap.mepc   = '0;                   // Interrupts resume at zero
        csr_trap.mtval  = '0;
        next_target     = {mtvec[`TRAP_XLEN-1:2], 2'b00};
        if (take_exc) begin
            csr_trap.mcause = {{(`TRAP_XLEN-5){1'b0}}, exc_req.cause};
            csr_trap.mepc   = exc_req.pc;
            csr_trap.mtval  = exc_req.tval;
        end else if (take_int) begin
            csr_trap.mcause = int_cause;
            next_target     = int_tvec;
        end else if (take_ret) begin
            next_target     = mepc;
        end
    end

    always_ff @(posedge g_clk) begin
        if (rst) begin
            hold <= 1'b0;
        end else if (take_exc || take_ret || take_int) begin
            hold <= 1'b1;
        end else if (trap_cf_ack) begin
            hold <= 1'b0;                       // Free again next cycle
        end
    end

    always_ff @(posedge g_clk) begin
        if (take_exc || take_ret || take_int) begin
            trap_cf_target <= next_target;
        end
    end

    assign trap_cf_valid = hold;

endmodule

// File: hw/cf_arbiter.sv
// ------------------------------
// Control-flow arbiter
// Trap redirect beats branch redirect, a losing branch is cancelled
// ------------------------------
`timescale 1ns/1ps
`include "trap_config.svh"

module cf_arbiter (
    input  logic                  br_valid,        // Branch redirect
    input  logic [`TRAP_XLEN-1:0] br_target,       // Branch address
    output logic                  br_ack,          // Branch consumed
    output logic                  br_cancel,       // Branch dropped
    input  logic                  trap_cf_valid,   // Trap redirect held
    input  logic [`TRAP_XLEN-1:0] trap_cf_target,  // Trap address
    output logic                  trap_cf_ack,     // Trap consumed
    output logic                  cf_valid,        // Outgoing redirect
    output logic [`TRAP_XLEN-1:0] cf_target,       // Outgoing address
    input  logic                  cf_ack           // Consumer accepts
);

    // Bus ownership -----------------
    assign cf_valid    = trap_cf_valid || br_valid;
    assign cf_target   = trap_cf_valid ? trap_cf_target : br_target;

    // Route the acknowledge to the winner
    assign trap_cf_ack = trap_cf_valid && cf_ack;
    assign br_ack      = !trap_cf_valid && br_valid && cf_ack;

    // Branch is stale once a trap is taken
    assign br_cancel   = trap_cf_valid && br_valid;

endmodule

// File: hw/trap_ctrl_top.sv
// ------------------------------
// Trap controller top level
// CSR file, interrupt priority, trap sequencer and redirect arbiter
// ------------------------------
`timescale 1ns/1ps
`include "trap_config.svh"

module trap_ctrl_top (
    input  logic                  g_clk,       // Core clock
    input  logic                  rst,         // Sync reset, active high
    input  trap_pkg::apb_req_t    apb_req,     // CSR access
    output trap_pkg::apb_rsp_t    apb_rsp,     // CSR response
    input  trap_pkg::irq_vec_t    irq,         // Interrupt lines
    input  logic                  exc_valid,   // Exception from writeback
    input  trap_pkg::trap_req_t   exc_req,     // Exception details
    output logic                  exc_ready,   // Exception taken
    input  logic                  mret_valid,  // Trap return
    output logic                  mret_ready,  // Return taken
    input  logic                  br_valid,    // Branch from execute
    input  logic [`TRAP_XLEN-1:0] br_target,   // Branch address
    output logic                  br_ack,      // Branch consumed
    output logic                  br_cancel,   // Branch dropped
    output logic                  cf_valid,    // Control-flow change
    output logic [`TRAP_XLEN-1:0] cf_target,   // Change destination
    input  logic                  cf_ack       // Change accepted
);

    import trap_pkg::*;

    // Internal wiring ---------------
    irq_vec_t              mip;             // Sampled lines
    irq_vec_t              mie;             // Enables
    logic                  mstatus_mie;     // Global enable
    logic [`TRAP_XLEN-1:0] mtvec;           // Vector base and mode
    logic [`TRAP_XLEN-1:0] mepc;            // Return address
    logic                  int_request;     // Interrupt to take
    logic [`TRAP_XLEN-1:0] int_cause;       // Interrupt cause word
    logic [`TRAP_XLEN-1:0] int_tvec;        // Interrupt handler
    csr_trap_t             csr_trap;        // Entry / return update
    logic                  trap_cf_valid;   // Trap redirect held
    logic [`TRAP_XLEN-1:0] trap_cf_target;  // Trap redirect address
    logic                  trap_cf_ack;     // Trap redirect consumed

    csr_file u_csr_file (
        .g_clk       (g_clk),
        .rst         (rst),
        .apb_req     (apb_req),
        .apb_rsp     (apb_rsp),
        .csr_trap    (csr_trap),
        .mip         (mip),
        .mstatus_mie (mstatus_mie),
        .mie         (mie),
        .mtvec       (mtvec),
        .mepc        (mepc)
    );

    irq_prio u_irq_prio (
        .g_clk       (g_clk),
        .rst         (rst),
        .irq         (irq),
        .mie         (mie),
        .mstatus_mie (mstatus_mie),
        .mtvec       (mtvec),
        .mip         (mip),
        .int_request (int_request),
        .int_cause   (int_cause),
        .int_tvec    (int_tvec)
    );

    trap_seq u_trap_seq (
        .g_clk          (g_clk),
        .rst            (rst),
        .exc_valid      (exc_valid),
        .exc_req        (exc_req),
        .exc_ready      (exc_ready),
        .mret_valid     (mret_valid),
        .mret_ready     (mret_ready),
        .int_request    (int_request),
        .int_cause      (int_cause),
        .int_tvec       (int_tvec),
        .mepc           (mepc),
        .mtvec          (mtvec),
        .csr_trap       (csr_trap),
        .trap_cf_valid  (trap_cf_valid),
        .trap_cf_target (trap_cf_target),
        .trap_cf_ack    (trap_cf_ack)
    );

    cf_arbiter u_cf_arbiter (
        .br_valid       (br_valid),
        .br_target      (br_target),
        .br_ack         (br_ack),
        .br_cancel      (br_cancel),
        .trap_cf_valid  (trap_cf_valid),
        .trap_cf_target (trap_cf_target),
        .trap_cf_ack    (trap_cf_ack),
        .cf_valid       (cf_valid),
        .cf_target      (cf_target),
        .cf_ack         (cf_ack)
    );

endmodule

// File: sim/tb_trap_ctrl.sv
// ------------------------------
// Trap controller testbench
// Replays the trace file step by step and checks every response
// ------------------------------
`timescale 1ns/1ps
`include "trap_config.svh"

module tb_trap_ctrl;

    import trap_pkg::*;

    logic                  g_clk = 1'b0;
    logic                  rst;
    apb_req_t              apb_req;
    apb_rsp_t              apb_rsp;
    irq_vec_t              irq;
    logic                  exc_valid;
    trap_req_t             exc_req;
    logic                  exc_ready;
    logic                  mret_valid;
    logic                  mret_ready;
    logic                  br_valid;
    logic [`TRAP_XLEN-1:0] br_target;
    logic                  br_ack;
    logic                  br_cancel;
    logic                  cf_valid;
    logic [`TRAP_XLEN-1:0] cf_target;
    logic                  cf_ack;

    integer seed   = 32'hf11c;  // Drives the cf_ack delays
    int     errors = 0;
    int     checks = 0;
    int     limit  = 0;         // Cycle budget, set once the trace is counted
    int     cycles = 0;

    trap_ctrl_top dut0 (.*);

    always #5 g_clk = ~g_clk;   // 10 ns period

    // Checking ----------------------
    task automatic check(input logic [8*12-1:0] step, input string what,
                         input logic [31:0] expected, input logic [31:0] actual);
        checks = checks + 1;
        if (expected !== actual) begin
            errors = errors + 1;
            $display("Fail %0s %0s: expected %h, actual %h", step, what, expected, actual);
        end
    endtask

    // Cycle limit from the trace length
    always @(posedge g_clk) begin
        cycles = cycles + 1;
        if (limit > 0 && cycles > limit) begin
            $display("Timeout: the trace did not finish within %0d cycles", limit);
            $display("Checks: %0d, errors: %0d", checks, errors + 1);
            $display("** FAIL **");
            $finish;
        end
    end

    // Bus tasks ---------------------
    // Setup cycle, access cycle, then idle
    task automatic apb_access(input logic [8*12-1:0] step, input logic write,
                              input logic [31:0] addr, input logic [31:0] data,
                              input logic [31:0] err);
        @(negedge g_clk);
        apb_req = '{psel: 1'b1, penable: 1'b0, pwrite: write,
                    paddr: addr[`TRAP_CSR_AW-1:0], pwdata: data};
        @(negedge g_clk);
        apb_req.penable = 1'b1;                   // Access cycle
        #1;
        check(step, "pready", 32'd1, 32'(apb_rsp.pready));
        check(step, "pslverr", err, 32'(apb_rsp.pslverr));
        if (!write && !err[0]) begin
            check(step, "prdata", data, apb_rsp.prdata);
        end
        @(negedge g_clk);
        apb_req = '0;
    endtask

    // Entered with cf_valid expected high, holds cf_ack low a random while
    task automatic follow_redirect(input logic [8*12-1:0] step, input logic [31:0] target);
        int delay;
        delay = $unsigned($random(seed)) % 4;     // 0 to 3 stall cycles
        check(step, "cf_valid", 32'd1, 32'(cf_valid));
        check(step, "cf_target", target, cf_target);
        check(step, "exc_ready while held", 32'd0, 32'(exc_ready));
        check(step, "mret_ready while held", 32'd0, 32'(mret_ready));
        repeat (delay) begin
            @(negedge g_clk);
            #1;
            check(step, "held cf_valid", 32'd1, 32'(cf_valid));
            check(step, "held cf_target", target, cf_target);
            check(step, "exc_ready while held", 32'd0, 32'(exc_ready));
        end
        @(negedge g_clk);
        cf_ack = 1'b1;
        @(negedge g_clk);
        cf_ack = 1'b0;
        #1;
        check(step, "cf_valid after ack", 32'd0, 32'(cf_valid));
        check(step, "exc_ready after ack", 32'd1, 32'(exc_ready));
    endtask

    // Exception (E), return (M) or exception raised with a branch (X)
    task automatic take_trap(input logic [8*12-1:0] step, input logic [7:0] op,
                             input logic [31:0] cause, pc, tval, target, branch);
        @(negedge g_clk);
        if (op == "M") begin
            mret_valid = 1'b1;
        end else begin
            exc_valid = 1'b1;
            exc_req   = '{cause: cause[4:0], pc: pc, tval: tval};
        end
        br_valid  = (op == "X");
        br_target = branch;
        #1;
        check(step, "exc_ready", 32'd1, 32'(exc_ready));    // No redirect held
        check(step, "mret_ready", 32'd1, 32'(mret_ready));
        @(negedge g_clk);                         // Taken at the edge before
        exc_valid  = 1'b0;
        mret_valid = 1'b0;
        if (op == "X") begin
            #1;
            check(step, "br_cancel", 32'd1, 32'(br_cancel));
            check(step, "br_ack", 32'd0, 32'(br_ack));
            @(negedge g_clk);
            br_valid = 1'b0;                      // Client drops after cancel
        end
        #1;
        follow_redirect(step, target);
    endtask

    // Lines are ext, sw, ti from bit 2 down
    task automatic drive_irq_lines(input logic [8*12-1:0] step, input logic [31:0] lines,
                                   input logic [31:0] taken, input logic [31:0] target);
        int waited;
        @(negedge g_clk);
        irq    = lines[2:0];
        waited = 0;
        if (taken[0]) begin
            while (!cf_valid && waited < 5) begin  // Sample, then take
                @(negedge g_clk);
                #1;
                waited = waited + 1;
            end
            if (cf_valid) begin
                follow_redirect(step, target);
            end else begin
                errors = errors + 1;
                $display("Interrupt in step %0s raised no redirect", step);
            end
        end else begin
            repeat (4) begin
                @(negedge g_clk);
                #1;
                check(step, "no cf_valid", 32'd0, 32'(cf_valid));
            end
        end
    endtask

    task automatic pass_branch(input logic [8*12-1:0] step, input logic [31:0] target);
        int delay;
        delay = $unsigned($random(seed)) % 4;
        @(negedge g_clk);
        br_valid  = 1'b1;
        br_target = target;
        #1;
        check(step, "cf_valid", 32'd1, 32'(cf_valid));
        check(step, "cf_target", target, cf_target);   // Same cycle pass-through
        repeat (delay) begin
            @(negedge g_clk);
            #1;
            check(step, "br_ack while held", 32'd0, 32'(br_ack));
        end
        @(negedge g_clk);
        cf_ack = 1'b1;
        #1;
        check(step, "br_ack", 32'd1, 32'(br_ack));
        check(step, "br_cancel", 32'd0, 32'(br_cancel));
        @(negedge g_clk);
        br_valid = 1'b0;
        cf_ack   = 1'b0;
        #1;
        check(step, "cf_valid after ack", 32'd0, 32'(cf_valid));
    endtask

    // Trace reading -----------------
    // Skips comment and blank lines
    task automatic read_step(input int fd, output logic found, output logic [8*12-1:0] name,
                             output logic [7:0] op, output logic [31:0] a, b, c, d, e);
        logic [8*160-1:0] line;
        int               n;
        found = 1'b0;
        while (!found && !$feof(fd)) begin
            line  = '0;
            n     = $fgets(line, fd);
            n     = $sscanf(line, "%s %s %h %h %h %h %h", name, op, a, b, c, d, e);
            found = (n == 7) && (name != 96'("#"));
        end
    endtask

    initial begin
        int               fd;
        int               steps;
        logic             found;
        logic [8*12-1:0]  name;
        logic [7:0]       op;
        logic [31:0]      a, b, c, d, e;
        rst        = 1'b1;
        apb_req    = '0;
        irq        = '0;
        exc_valid  = 1'b0;
        exc_req    = '0;
        mret_valid = 1'b0;
        br_valid   = 1'b0;
        br_target  = '0;
        cf_ack     = 1'b0;
        steps      = 0;
        fd = $fopen("sim/trap_trace.txt", "r");
        if (fd == 0) begin
            errors = errors + 1;
            $display("Cannot open the trace file sim/trap_trace.txt");
        end else begin
            found = 1'b1;
            while (found) begin                   // First pass counts steps
                read_step(fd, found, name, op, a, b, c, d, e);
                if (found) begin
                    steps = steps + 1;
                end
            end
            $fclose(fd);
            limit = steps * 20 + 50;
            repeat (5) @(negedge g_clk);
            rst = 1'b0;
            #1;
            check("reset", "cf_valid", 32'd0, 32'(cf_valid));
            check("reset", "br_ack", 32'd0, 32'(br_ack));
            check("reset", "br_cancel", 32'd0, 32'(br_cancel));
            check("reset", "pslverr", 32'd0, 32'(apb_rsp.pslverr));
            check("reset", "exc_ready", 32'd1, 32'(exc_ready));
            check("reset", "mret_ready", 32'd1, 32'(mret_ready));
            fd    = $fopen("sim/trap_trace.txt", "r");
            found = 1'b1;
            while (found) begin
                read_step(fd, found, name, op, a, b, c, d, e);
                if (!found) begin
                    // End of trace
                end else if (op == "W" || op == "R") begin
                    apb_access(name, op == "W", a, b, c);
                end else if (op == "E" || op == "M" || op == "X") begin
                    take_trap(name, op, a, b, c, d, e);
                end else if (op == "I") begin
                    drive_irq_lines(name, a, b, d);
                end else if (op == "B") begin
                    pass_branch(name, d);
                end else begin
                    errors = errors + 1;
                    $display("Step %0s has an unknown operation", name);
                end
            end
            $fclose(fd);
        end
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

// File: compile.f
+incdir+common
common/trap_pkg.sv
hw/csr/csr_file.sv
hw/irq/irq_prio.sv
hw/trap_seq.sv
hw/cf_arbiter.sv
hw/trap_ctrl_top.sv
sim/tb_trap_ctrl.sv

// File: Makefile
# Verilator build and run for the trap controller

VERILATOR := verilator
TOP       := tb_trap_ctrl
FILELIST  := compile.f
FLAGS     := --timing --top-module $(TOP)
OBJ_DIR   := obj_dir
LOG       := sim.log
PASS_MSG  := ^\*\* PASS \*\*$$

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(FLAGS) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q '$(PASS_MSG)' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: sim/trap_trace.txt
# name op a b c d e, all hex. W/R: addr data err. E/X: cause pc tval target branch
# M: target in d. I: lines (ext sw ti) taken, target in d. B: target in a and d
mie_wr       W 304 888 0 0 0
mie_rd       R 304 888 0 0 0
mtvec_wr     W 305 200 0 0 0
mtvec_rd     R 305 200 0 0 0
mepc_wr      W 341 1234 0 0 0
mepc_rd      R 341 1234 0 0 0
unmapped_rd  R 7c0 0 1 0 0
mip_wr       W 344 888 1 0 0
mip_rd       R 344 0 0 0 0
mstatus_wr   W 300 8 0 0 0
exc          E 2 80 dead 200 0
exc_mepc     R 341 80 0 0 0
exc_mcause   R 342 2 0 0 0
exc_mtval    R 343 dead 0 0 0
exc_mstatus  R 300 80 0 0 0
mret         M 0 0 0 80 0
mret_mstatus R 300 88 0 0 0
vectored_wr  W 305 201 0 0 0
irq_ext_ti   I 5 1 0 22c 0
irq_mcause   R 342 8000000b 0 0 0
irq_mip      R 344 880 0 0 0
irq_masked   I 2 0 0 0 0
masked_mip   R 344 8 0 0 0
irq_off      I 0 0 0 0 0
irq_mret     M 0 0 0 0 0
ret_mstatus  R 300 88 0 0 0
branch       B 400 0 0 400 0
br_exc       X 5 90 44 200 500
br_mcause    R 342 5 0 0 0
br_mepc      R 341 90 0 0 0
br_mtval     R 343 44 0 0 0
